/* bench/streamCountChecker.sv */
`timescale 1ns/1ps

module streamCountChecker #(
    parameter int slotWidth = graphPkg::defaultSlotWidth,
    parameter int queueDepthLog2 = 3,
    parameter int tagWidth = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic botValid,
    input  graphPkg::graphT graphIn,
    input  logic [tagWidth-1:0] tagIn,
    input  graphPkg::countT hintCount,
    input  logic slowDown,
    input  logic resultValid,
    input  graphPkg::countT connectCount,
    input  logic [tagWidth-1:0] tagOut,
    output int checkedCount,
    output int errorCount,
    output int pendingCount,
    output logic slowDownSeen
);

    // Every result comes out exactly one ring after its input
    localparam int ringLen = 2 ** slotWidth;
    // Queue occupancy above this raises slowDown
    localparam int almostFull = 2 ** queueDepthLog2 - 3;

    // Expected results in input order
    int dueCycle [$];
    logic [tagWidth-1:0] dueTag [$];
    graphPkg::countT dueCount [$];

    // Inputs as seen at the last rising edge
    int cycle;
    logic sampledReset;
    logic sampledValid;
    graphPkg::graphT sampledGraph;
    logic [tagWidth-1:0] sampledTag;
    graphPkg::countT sampledHint;

    // Union-find over the edge list, bit 0 is pair (0,1), row by row
    function automatic graphPkg::countT unionFindCount(input graphPkg::graphT g);
        int parent [graphPkg::numNodes];
        graphPkg::graphT rest;
        int ra;
        int rb;
        int roots;
        rest = g;
        for (int i = 0; i < graphPkg::numNodes; i++) begin
            parent[i] = i;
        end
        for (int a = 0; a < graphPkg::numNodes; a++) begin
            for (int b = a + 1; b < graphPkg::numNodes; b++) begin
                if (rest[0]) begin
                    ra = a;
                    while (parent[ra] != ra) ra = parent[ra];
                    rb = b;
                    while (parent[rb] != rb) rb = parent[rb];
                    if (ra != rb) parent[rb] = ra;
                end
                rest = rest >> 1;
            end
        end
        roots = 0;
        for (int i = 0; i < graphPkg::numNodes; i++) begin
            if (parent[i] == i) roots++;
        end
        return graphPkg::countT'(roots);
    endfunction

    task automatic dropFront();
        void'(dueCycle.pop_front());
        void'(dueTag.pop_front());
        void'(dueCount.pop_front());
    endtask

    task automatic compareResult();
        logic ok;
        ok = 1'b1;
        if (tagOut !== dueTag[0]) begin
            $display("[FAIL] tagOut expected 0x%h actual 0x%h", dueTag[0], tagOut);
            ok = 1'b0;
        end
        if (connectCount !== dueCount[0]) begin
            $display("[FAIL] connectCount expected 0x%h actual 0x%h", dueCount[0], connectCount);
            ok = 1'b0;
        end
        checkedCount++;
        if (ok) begin
            $display("[PASS] result %0d tag 0x%h count 0x%h", checkedCount, tagOut, connectCount);
        end else begin
            errorCount++;
        end
        dropFront();
    endtask

    initial begin
        cycle = 0;
        sampledReset = 1'b0;
        sampledValid = 1'b0;
        checkedCount = 0;
        errorCount = 0;
        pendingCount = 0;
        slowDownSeen = 1'b0;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        sampledReset = !rstN;
        sampledValid = botValid;
        sampledGraph = graphIn;
        sampledTag = tagIn;
        sampledHint = hintCount;
    end

    always @(negedge clk) begin
        graphPkg::countT model;
        if (sampledReset) begin
            if (resultValid !== 1'b0 || slowDown !== 1'b0) begin
                $display("resultValid or slowDown is not low during reset at cycle %0d", cycle);
                errorCount++;
            end
        end else begin
            if (sampledValid) begin
                model = unionFindCount(sampledGraph);
                // Table entries carry their own count, a zero means none
                if (sampledHint != '0 && sampledHint != model) begin
                    $display("Reference model gives 0x%h but the table expects 0x%h for tag 0x%h",
                             model, sampledHint, sampledTag);
                    errorCount++;
                end
                dueCycle.push_back(cycle + ringLen);
                dueTag.push_back(sampledTag);
                dueCount.push_back(model);
            end
            if (slowDown === 1'b1) begin
                slowDownSeen = 1'b1;
                // Every queued entry is an input still waiting for its result
                if (dueCycle.size() <= almostFull) begin
                    $display("slowDown is high with only %0d inputs in flight at cycle %0d",
                             dueCycle.size(), cycle);
                    errorCount++;
                end
            end
            if (resultValid === 1'b1) begin
                if (dueCycle.size() == 0 || dueCycle[0] != cycle) begin
                    $display("Unexpected output at cycle %0d with no input due", cycle);
                    errorCount++;
                end else begin
                    compareResult();
                end
            end else if (dueCycle.size() != 0 && dueCycle[0] == cycle) begin
                $display("Missing output at cycle %0d for tag 0x%h", cycle, dueTag[0]);
                errorCount++;
                dropFront();
            end
        end
        pendingCount = dueCycle.size();
    end

endmodule

/* bench/streamCountTb.sv */
`timescale 1ns/1ps

module streamCountTb;

    localparam int slotWidth = graphPkg::defaultSlotWidth;
    localparam int queueDepthLog2 = 3;
    localparam int tagWidth = 4;
    localparam int tableLen = 17;
    localparam int randomItems = 200;
    localparam int ringLen = 2 ** slotWidth;

    logic clk;
    logic rstN;
    logic botValid;
    graphPkg::graphT graphIn;
    logic [tagWidth-1:0] tagIn;
    graphPkg::countT hintCount;
    logic slowDown;
    logic resultValid;
    graphPkg::countT connectCount;
    logic [tagWidth-1:0] tagOut;

    int checkedCount;
    int errorCount;
    int pendingCount;
    logic slowDownSeen;
    int sentCount;
    int cycleCount;
    int timeoutLimit;
    int seed;

    // Stimulus table with expected counts
    graphPkg::graphT tblGraph [tableLen];
    logic [tagWidth-1:0] tblTag [tableLen];
    graphPkg::countT tblCount [tableLen];
    int tblGap [tableLen];

    streamCountTop #(
        .slotWidth(slotWidth),
        .queueDepthLog2(queueDepthLog2),
        .tagWidth(tagWidth)
    ) u_dut (
        .clk(clk),
        .rstN(rstN),
        .botValid(botValid),
        .graphIn(graphIn),
        .tagIn(tagIn),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .tagOut(tagOut)
    );

    streamCountChecker #(
        .slotWidth(slotWidth),
        .queueDepthLog2(queueDepthLog2),
        .tagWidth(tagWidth)
    ) scoreboard (
        .clk(clk),
        .rstN(rstN),
        .botValid(botValid),
        .graphIn(graphIn),
        .tagIn(tagIn),
        .hintCount(hintCount),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .tagOut(tagOut),
        .checkedCount(checkedCount),
        .errorCount(errorCount),
        .pendingCount(pendingCount),
        .slowDownSeen(slowDownSeen)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout, the run went past %0d cycles", timeoutLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    // One edge of the upper triangle, pairs numbered row by row
    function automatic graphPkg::graphT pairBit(input int i, input int j);
        return graphPkg::graphT'(1) << (i * (2 * graphPkg::numNodes - i - 1) / 2 + j - i - 1);
    endfunction

    task automatic buildTable();
        int pick;
        tblGraph[0] = '0;
        tblCount[0] = 8;
        tblGraph[1] = '1;
        tblCount[1] = 1;
        tblGraph[2] = '0;
        for (int i = 0; i < graphPkg::numNodes - 1; i++) begin
            tblGraph[2] = tblGraph[2] | pairBit(i, i + 1);
        end
        tblCount[2] = 1;
        // Two triangles, nodes 6 and 7 alone
        tblGraph[3] = pairBit(0, 1) | pairBit(0, 2) | pairBit(1, 2)
                    | pairBit(3, 4) | pairBit(3, 5) | pairBit(4, 5);
        tblCount[3] = 4;
        // Star on node 0, pair 5-6, node 7 alone
        tblGraph[4] = pairBit(0, 1) | pairBit(0, 2) | pairBit(0, 3) | pairBit(0, 4)
                    | pairBit(5, 6);
        tblCount[4] = 3;
        for (int k = 0; k < 5; k++) begin
            tblTag[k] = tagWidth'(k + 1);
            tblGap[k] = k;
        end
        // Back-to-back burst mixing slow and fast graphs
        for (int b = 0; b < tableLen - 5; b++) begin
            pick = (b * 3) % 5;
            tblGraph[5 + b] = tblGraph[pick];
            tblCount[5 + b] = tblCount[pick];
            tblTag[5 + b] = tagWidth'(b + 6);
            tblGap[5 + b] = 0;
        end
    endtask

    function automatic int tableCycles();
        int total;
        total = 0;
        for (int k = 0; k < tableLen; k++) begin
            total += tblGap[k] + 12;
        end
        return total;
    endfunction

    // Called just after a falling edge, returns on one
    task automatic sendItem(input graphPkg::graphT g, input logic [tagWidth-1:0] t,
                            input graphPkg::countT c, input int gap);
        while (slowDown) @(negedge clk);
        botValid = 1'b1;
        graphIn = g;
        tagIn = t;
        hintCount = c;
        sentCount++;
        @(negedge clk);
        botValid = 1'b0;
        hintCount = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic runRandomPhase();
        logic [31:0] raw;
        int density;
        int gap;
        for (int k = 0; k < randomItems; k++) begin
            raw = $random(seed);
            // More masking gives sparser graphs
            density = $random(seed) & 3;
            repeat (density) raw = raw & $random(seed);
            gap = $random(seed) & 3;
            sendItem(graphPkg::graphT'(raw), tagWidth'($random(seed)), '0, gap);
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        botValid = 1'b0;
        graphIn = '0;
        tagIn = '0;
        hintCount = '0;
        seed = 17054;
        sentCount = 0;
        cycleCount = 0;
        buildTable();
        timeoutLimit = tableCycles() + randomItems * 12 + 200;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        // Quiet stretch before the first input
        repeat (10) @(negedge clk);
        for (int k = 0; k < tableLen; k++) begin
            sendItem(tblGraph[k], tblTag[k], tblCount[k], tblGap[k]);
        end
        runRandomPhase();
        repeat (2) @(negedge clk);
        while (pendingCount != 0) @(negedge clk);
        // One more lap so stray outputs get caught
        repeat (ringLen + 8) @(negedge clk);
        $display("%0d sent, %0d checked, %0d errors", sentCount, checkedCount, errorCount);
        if (errorCount == 0 && checkedCount == sentCount && slowDownSeen) begin
            $display("Test OK");
        end else begin
            if (checkedCount != sentCount) begin
                $display("Only %0d of %0d inputs produced a result", checkedCount, sentCount);
            end
            if (!slowDownSeen) begin
                $display("slowDown never went high, the burst did not fill the queue");
            end
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module streamCountTb -o streamCountSim

output=$(./obj_dir/streamCountSim)
echo "$output"

if grep -qx "Test OK" <<< "$output"; then
    exit 0
fi
exit 1

/* verilog/componentCounter.sv */
`timescale 1ns/1ps

module componentCounter #(
    parameter int slotWidth = graphPkg::defaultSlotWidth
) (
    input  logic clk,
    input  logic rstN,
    output logic request,
    input  logic start,
    input  graphPkg::graphT graphIn,
    input  logic [slotWidth-1:0] slotIn,
    resultBus.producer res
);

    localparam int n = graphPkg::numNodes;
    localparam int labelWidth = $clog2(n);

    typedef logic [labelWidth-1:0] labelT;

    ctrlPkg::counterStateT state;
    graphPkg::graphT graphReg;
    logic [slotWidth-1:0] slotReg;
    logic [n-1:0][n-1:0] adjacency;
    labelT [n-1:0] labels;
    labelT [n-1:0] nextLabels;
    graphPkg::countT rootCount;
    graphPkg::countT countReg;

    // Symmetric neighbor matrix from the upper-triangle mask
    function automatic logic [n-1:0][n-1:0] expandMask(input graphPkg::graphT mask);
        logic [n-1:0][n-1:0] adj;
        int bitIdx;
        adj = '0;
        bitIdx = 0;
        for (int i = 0; i < n; i++) begin
            for (int j = i + 1; j < n; j++) begin
                adj[i][j] = mask[bitIdx];
                adj[j][i] = mask[bitIdx];
                bitIdx++;
            end
        end
        return adj;
    endfunction

    // One propagation step, min over the node and its neighbors
    always_comb begin
        labelT best;
        for (int i = 0; i < n; i++) begin
            best = labels[i];
            for (int j = 0; j < n; j++) begin
                if (adjacency[i][j] && labels[j] < best) begin
                    best = labels[j];
                end
            end
            nextLabels[i] = best;
        end
    end

    // Each component keeps exactly one node labelled with itself
    always_comb begin
        rootCount = '0;
        for (int i = 0; i < n; i++) begin
            if (labels[i] == labelT'(i)) begin
                rootCount = rootCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= ctrlPkg::IDLE;
        end else begin
            case (state)
                ctrlPkg::IDLE: if (start) state <= ctrlPkg::LOAD;
                ctrlPkg::LOAD: state <= ctrlPkg::PROPAGATE;
                ctrlPkg::PROPAGATE: if (nextLabels == labels) state <= ctrlPkg::TALLY;
                ctrlPkg::TALLY: state <= ctrlPkg::HOLD;
                ctrlPkg::HOLD: if (res.grant) state <= ctrlPkg::IDLE;
                default: state <= ctrlPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ctrlPkg::IDLE && start) begin
            graphReg <= graphIn;
            slotReg <= slotIn;
        end
        if (state == ctrlPkg::LOAD) begin
            adjacency <= expandMask(graphReg);
            for (int i = 0; i < n; i++) begin
                labels[i] <= labelT'(i);
            end
        end
        if (state == ctrlPkg::PROPAGATE) begin
            labels <= nextLabels;
        end
        if (state == ctrlPkg::TALLY) begin
            countReg <= rootCount;
        end
    end

    assign request = state == ctrlPkg::IDLE;
    assign res.done = state == ctrlPkg::HOLD;
    assign res.count = countReg;
    assign res.slot = slotReg;

endmodule

/* verilog/ctrlPkg.sv */
package ctrlPkg;

    // Component counter FSM
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        PROPAGATE,
        TALLY,
        HOLD
    } counterStateT;

    // Owner of the result memory write port
    typedef enum logic [1:0] {
        NONE,
        CORE0,
        CORE1
    } grantT;

endpackage

/* verilog/graphPkg.sv */
package graphPkg;

    // Nodes per graph
    localparam int numNodes = 8;

    // One bit per unordered node pair
    localparam int edgeBits = numNodes * (numNodes - 1) / 2;

    // Upper-triangle edge mask, bit 0 is pair (0,1), then (0,2) up to (0,7),
    // then (1,2) and so on, ending with pair (6,7) in the top bit
    typedef logic [edgeBits-1:0] graphT;

    // Component count, 1 to numNodes
    typedef logic [$clog2(numNodes+1)-1:0] countT;

    // Ring of 64 result slots
    localparam int defaultSlotWidth = 6;

endpackage

/* verilog/graphQueue.sv */
`timescale 1ns/1ps

module graphQueue #(
    parameter int slotWidth = graphPkg::defaultSlotWidth,
    parameter int queueDepthLog2 = 3
) (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  graphPkg::graphT graphIn,
    input  logic [slotWidth-1:0] slotIn,
    output logic slowDown,
    input  logic request0,
    input  logic request1,
    output logic start0,
    output logic start1,
    output graphPkg::graphT graphOut,
    output logic [slotWidth-1:0] slotOut
);

    localparam int depth = 2 ** queueDepthLog2;
    // Leaves room for the inputs already in flight when slowDown rises
    localparam int almostFull = depth - 3;

    graphPkg::graphT graphMem [depth];
    logic [slotWidth-1:0] slotMem [depth];
    logic [queueDepthLog2-1:0] wrPtr;
    logic [queueDepthLog2-1:0] rdPtr;
    logic [queueDepthLog2:0] occupancy;
    logic preferOne;
    logic empty;
    logic full;
    logic doPush;
    logic eligible0;
    logic eligible1;
    logic pop0;
    logic pop1;
    logic pop;

    assign empty = occupancy == '0;
    assign full = occupancy == (queueDepthLog2 + 1)'(depth);
    assign slowDown = occupancy > (queueDepthLog2 + 1)'(almostFull);

    // A pop frees the slot the push needs
    assign doPush = push && (!full || pop);

    // A counter still requests in the cycle its start pulse is out
    assign eligible0 = request0 && !start0;
    assign eligible1 = request1 && !start1;

    assign pop0 = !empty && eligible0 && (!eligible1 || !preferOne);
    assign pop1 = !empty && eligible1 && (!eligible0 || preferOne);
    assign pop = pop0 || pop1;

    // Entry storage and output register
    always_ff @(posedge clk) begin
        if (doPush) begin
            graphMem[wrPtr] <= graphIn;
            slotMem[wrPtr] <= slotIn;
        end
        if (pop) begin
            graphOut <= graphMem[rdPtr];
            slotOut <= slotMem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            occupancy <= '0;
            preferOne <= 1'b0;
            start0 <= 1'b0;
            start1 <= 1'b0;
        end else begin
            start0 <= pop0;
            start1 <= pop1;
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
                // Other counter goes first next time
                preferOne <= pop0;
            end
            case ({doPush, pop})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

/* verilog/resultArbiter.sv */
`timescale 1ns/1ps

module resultArbiter #(
    parameter int slotWidth = graphPkg::defaultSlotWidth
) (
    input  logic clk,
    input  logic rstN,
    resultBus.arbiter bus0,
    resultBus.arbiter bus1,
    output logic writeEnable,
    output logic [slotWidth-1:0] writeAddr,
    output graphPkg::countT writeData
);

    ctrlPkg::grantT grantSel;
    logic preferOne;
    logic contested;

    assign contested = bus0.done && bus1.done;

    always_comb begin
        if (contested) begin
            if (preferOne) begin
                grantSel = ctrlPkg::CORE1;
            end else begin
                grantSel = ctrlPkg::CORE0;
            end
        end else if (bus0.done) begin
            grantSel = ctrlPkg::CORE0;
        end else if (bus1.done) begin
            grantSel = ctrlPkg::CORE1;
        end else begin
            grantSel = ctrlPkg::NONE;
        end
    end

    assign bus0.grant = grantSel == ctrlPkg::CORE0;
    assign bus1.grant = grantSel == ctrlPkg::CORE1;
    assign writeEnable = grantSel != ctrlPkg::NONE;

    // Winner's slot and count onto the write port
    always_comb begin
        if (grantSel == ctrlPkg::CORE1) begin
            writeAddr = bus1.slot;
            writeData = bus1.count;
        end else begin
            writeAddr = bus0.slot;
            writeData = bus0.count;
        end
    end

    // Loser of a contest wins the next one
    always_ff @(posedge clk) begin
        if (!rstN) begin
            preferOne <= 1'b0;
        end else if (contested) begin
            preferOne <= !preferOne;
        end
    end

endmodule

/* verilog/resultBus.sv */
`timescale 1ns/1ps

interface resultBus #(
    parameter int slotWidth = graphPkg::defaultSlotWidth
);

    // Level, held until the arbiter grants
    logic done;
    graphPkg::countT count;
    logic [slotWidth-1:0] slot;
    // Combinational, same cycle as done
    logic grant;

    modport producer (
        output done,
        output count,
        output slot,
        input  grant
    );

    modport arbiter (
        input  done,
        input  count,
        input  slot,
        output grant
    );

endinterface

/* verilog/resultMemory.sv */
`timescale 1ns/1ps

module resultMemory #(
    parameter int slotWidth = graphPkg::defaultSlotWidth,
    parameter int tagWidth = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic writeEnable,
    input  logic [slotWidth-1:0] writeAddr,
    input  graphPkg::countT writeData,
    input  logic [slotWidth-1:0] readSlot,
    input  logic validIn,
    input  logic [tagWidth-1:0] tagIn,
    output logic resultValid,
    output graphPkg::countT connectCount,
    output logic [tagWidth-1:0] tagOut
);

    localparam int depth = 2 ** slotWidth;

    graphPkg::countT countMem [depth];
    // Valid bit on top, tag below
    logic [tagWidth:0] validTagMem [depth];
    logic ringPrimed;

    // Counts arrive from the arbiter at the item's slot
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            countMem[writeAddr] <= writeData;
        end
        connectCount <= countMem[readSlot];
    end

    // Same address written and read every cycle, read sees last lap's entry
    always_ff @(posedge clk) begin
        validTagMem[readSlot] <= {validIn, tagIn};
        tagOut <= validTagMem[readSlot][tagWidth-1:0];
    end

    // Slots hold nothing valid until the first lap after reset completes
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            ringPrimed <= 1'b0;
        end else begin
            resultValid <= ringPrimed && validTagMem[readSlot][tagWidth];
            if (readSlot == '1) begin
                ringPrimed <= 1'b1;
            end
        end
    end

endmodule

/* verilog/streamCountTop.sv */
`timescale 1ns/1ps

module streamCountTop #(
    parameter int slotWidth = graphPkg::defaultSlotWidth,
    parameter int queueDepthLog2 = 3,
    parameter int tagWidth = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic botValid,
    input  graphPkg::graphT graphIn,
    input  logic [tagWidth-1:0] tagIn,
    output logic slowDown,
    output logic resultValid,
    output graphPkg::countT connectCount,
    output logic [tagWidth-1:0] tagOut
);

    logic [slotWidth-1:0] slot;
    logic request0;
    logic request1;
    logic start0;
    logic start1;
    graphPkg::graphT queueGraph;
    logic [slotWidth-1:0] queueSlot;
    logic writeEnable;
    logic [slotWidth-1:0] writeAddr;
    graphPkg::countT writeData;

    // Rolling slot index, one step per cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    resultBus #(.slotWidth(slotWidth)) bus0 ();
    resultBus #(.slotWidth(slotWidth)) bus1 ();

    graphQueue #(
        .slotWidth(slotWidth),
        .queueDepthLog2(queueDepthLog2)
    ) queue (
        .clk(clk),
        .rstN(rstN),
        .push(botValid),
        .graphIn(graphIn),
        .slotIn(slot),
        .slowDown(slowDown),
        .request0(request0),
        .request1(request1),
        .start0(start0),
        .start1(start1),
        .graphOut(queueGraph),
        .slotOut(queueSlot)
    );

    // Both counters share the queue output, start picks the owner
    componentCounter #(.slotWidth(slotWidth)) counter0 (
        .clk(clk),
        .rstN(rstN),
        .request(request0),
        .start(start0),
        .graphIn(queueGraph),
        .slotIn(queueSlot),
        .res(bus0.producer)
    );

    componentCounter #(.slotWidth(slotWidth)) counter1 (
        .clk(clk),
        .rstN(rstN),
        .request(request1),
        .start(start1),
        .graphIn(queueGraph),
        .slotIn(queueSlot),
        .res(bus1.producer)
    );

    resultArbiter #(.slotWidth(slotWidth)) arbiter (
        .clk(clk),
        .rstN(rstN),
        .bus0(bus0.arbiter),
        .bus1(bus1.arbiter),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    resultMemory #(
        .slotWidth(slotWidth),
        .tagWidth(tagWidth)
    ) memory (
        .clk(clk),
        .rstN(rstN),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readSlot(slot),
        .validIn(botValid),
        .tagIn(tagIn),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .tagOut(tagOut)
    );

endmodule

/* vlog.f */
verilog/graphPkg.sv
verilog/ctrlPkg.sv
verilog/resultBus.sv
verilog/graphQueue.sv
verilog/componentCounter.sv
verilog/resultArbiter.sv
verilog/resultMemory.sv
verilog/streamCountTop.sv
bench/streamCountChecker.sv
bench/streamCountTb.sv
